//--- slim_mac.f
+incdir+verif
verilog/slim_mac_pkg.sv
verilog/tile_issue_if.sv
verilog/weight_bank_store.sv
verilog/tile_decode.sv
verilog/mac_execute.sv
verilog/bias_result.sv
verilog/slim_mac_top.sv
verif/slim_mac_tb.sv

//--- Makefile
# Verilator build and run for the tile MAC engine testbench

VERILATOR ?= verilator
TOP       ?= slim_mac_tb
FILELIST  ?= slim_mac.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS    := $(shell grep -v '^+' $(FILELIST))
HDRS    := verif/slim_mac_model.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/slim_mac_model.svh
// =========================================================================
// reference model of the tile MAC engine
// included inside the testbench module and built on its size constants
// keeps shadow copies of every accepted load and predicts result vectors
// =========================================================================
`ifndef SLIM_MAC_MODEL_SVH
`define SLIM_MAC_MODEL_SVH

// shadow copies of the loaded weights, xt vectors and biases
logic [WORD_W-1:0] model_w    [TPJ];
logic [VEC_W-1:0]  model_xt   [XT_DEPTH];
logic [VEC_W-1:0]  model_bias [TPJ];

// record one load that the engine accepts
function automatic void model_store(load_target_e target, int addr,
                                    logic [WORD_W-1:0] data);
    case (target)
        LOAD_WEIGHT: model_w[addr]    = data;
        // xt and bias use the low lanes of the load word only
        LOAD_XT:     model_xt[addr]   = data[VEC_W-1:0];
        LOAD_BIAS:   model_bias[addr] = data[VEC_W-1:0];
        default: ;
    endcase
endfunction

// expected result vector of tile t
function automatic logic [VEC_W-1:0] expected_result(int t);
    logic [VEC_W-1:0]            res;
    logic [VEC_W-1:0]            xv;
    logic signed [DATA_WIDTH-1:0] w_e;
    logic signed [DATA_WIDTH-1:0] x_e;
    logic signed [ACC_WIDTH-1:0] acc;
    logic signed [ACC_WIDTH-1:0] shifted;
    longint                      prod;
    res = '0;
    // one xt vector serves X_GROUP consecutive tiles
    xv = model_xt[t / X_GROUP];
    for (int i = 0; i < TILE_SIZE; i++) begin
        acc = '0;
        for (int j = 0; j < TILE_SIZE; j++) begin
            w_e  = model_w[t][(i*TILE_SIZE+j)*DATA_WIDTH +: DATA_WIDTH];
            x_e  = xv[j*DATA_WIDTH +: DATA_WIDTH];
            prod = longint'(w_e) * longint'(x_e);
            // sum wraps at ACC_WIDTH bits
            acc  = acc + prod[ACC_WIDTH-1:0];
        end
        shifted = acc >>> FRAC_BITS;
        res[i*DATA_WIDTH +: DATA_WIDTH] = shifted[DATA_WIDTH-1:0]
                                        + model_bias[t][i*DATA_WIDTH +: DATA_WIDTH];
    end
    return res;
endfunction

`endif

//--- verif/slim_mac_tb.sv
// =========================================================================
// testbench for the tile MAC engine
// loads random weights, xt and biases, runs several jobs with random
// done back-pressure and ignored loads, checks against the model
// =========================================================================
module slim_mac_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import slim_mac_pkg::*;

    localparam int TILE_SIZE  = TILE_SIZE_D;
    localparam int DATA_WIDTH = DATA_WIDTH_D;
    localparam int ACC_WIDTH  = ACC_WIDTH_D;
    localparam int FRAC_BITS  = FRAC_BITS_D;
    localparam int TPJ        = TILES_PER_JOB_D;
    localparam int X_GROUP    = X_GROUP_D;
    localparam int XT_DEPTH   = (TPJ + X_GROUP - 1) / X_GROUP;
    localparam int WORD_W     = TILE_SIZE * TILE_SIZE * DATA_WIDTH;
    localparam int VEC_W      = TILE_SIZE * DATA_WIDTH;
    localparam int IDX_W      = (TPJ > 1) ? $clog2(TPJ) : 1;
    // edges from the accept edge to the first result
    localparam int RESULT_LAT = 5;
    localparam int N_JOBS     = 4;
    localparam int MAX_STALL  = 6;
    localparam int LOAD_CYCLES  = 2 * TPJ + XT_DEPTH + 4;
    localparam int WATCHDOG_CYC = 10 + 10 + LOAD_CYCLES + N_JOBS * (TPJ + 20 + 2 * MAX_STALL);

    logic                      clk;
    logic                      rst_n;
    logic                      s_tvalid;
    logic                      s_tready;
    logic                      m_tvalid;
    logic                      m_tready;
    logic                      load_en;
    load_target_e              load_target;
    logic [IDX_W-1:0]          load_addr;
    logic [WORD_W-1:0]         load_data;
    logic                      result_valid;
    logic [IDX_W-1:0]          result_tile;
    logic [VEC_W-1:0]          result_vec;

    string cur_test;
    int    test_errors;
    int    total_errors;
    int    failed_tests;
    int    tests_run;

    `include "slim_mac_model.svh"

    slim_mac_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .s_tvalid     (s_tvalid),
        .s_tready     (s_tready),
        .m_tvalid     (m_tvalid),
        .m_tready     (m_tready),
        .load_en      (load_en),
        .load_target  (load_target),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .result_valid (result_valid),
        .result_tile  (result_tile),
        .result_vec   (result_vec)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ======================================================================
    // helpers
    // ======================================================================
    task automatic check_equal(string what, logic [63:0] expected, logic [63:0] actual);
        assert (expected === actual) else begin
            $display("** Error [%s] %s: expected %h, actual %h",
                     cur_test, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic close_test();
        if (test_errors == 0) begin
            $display("test %-8s ok", cur_test);
        end else begin
            $display("test %-8s FAIL with %0d errors", cur_test, test_errors);
            failed_tests++;
        end
        total_errors += test_errors;
        tests_run++;
        test_errors = 0;
    endtask

    function automatic logic [WORD_W-1:0] rand_word();
        logic [WORD_W-1:0] w;
        for (int k = 0; k < WORD_W / 32; k++) begin
            w[k*32 +: 32] = $urandom;
        end
        return w;
    endfunction

    // one load cycle while idle, mirrored into the model
    task automatic write_load(load_target_e target, int addr);
        logic [WORD_W-1:0] data;
        data = rand_word();
        @(posedge clk);
        load_en     <= 1'b1;
        load_target <= target;
        load_addr   <= IDX_W'(addr);
        load_data   <= data;
        model_store(target, addr, data);
    endtask

    // random load traffic that the engine must ignore, model untouched
    task automatic drive_ignored_load();
        load_en     <= 1'($urandom_range(0, 1));
        load_target <= load_target_e'($urandom_range(0, 2));
        load_addr   <= IDX_W'($urandom_range(0, 2**IDX_W - 1));
        load_data   <= rand_word();
    endtask

    task automatic run_job();
        int stall;
        stall = $urandom_range(1, MAX_STALL);
        // starts are blocked while m_tready is low
        @(posedge clk);
        s_tvalid <= 1'b1;
        m_tready <= 1'b0;
        repeat (stall) begin
            @(negedge clk);
            check_equal("s_tready with m_tready low", 64'(0), 64'(s_tready));
            @(posedge clk);
        end
        m_tready <= 1'b1;
        @(negedge clk);
        check_equal("s_tready in idle", 64'(1), 64'(s_tready));
        // accept edge
        @(posedge clk);
        s_tvalid <= 1'b0;
        m_tready <= 1'b0;
        drive_ignored_load();
        for (int e = 1; e <= TPJ + RESULT_LAT; e++) begin
            @(posedge clk);
            drive_ignored_load();
            @(negedge clk);
            if (e < RESULT_LAT) begin
                check_equal("result_valid before first tile", 64'(0), 64'(result_valid));
            end else if (e < RESULT_LAT + TPJ) begin
                check_equal("result_valid", 64'(1), 64'(result_valid));
                check_equal("result_tile", 64'(e - RESULT_LAT), 64'(result_tile));
                check_equal($sformatf("result_vec tile %0d", e - RESULT_LAT),
                            64'(expected_result(e - RESULT_LAT)), 64'(result_vec));
            end else begin
                check_equal("result_valid after last tile", 64'(0), 64'(result_valid));
            end
            check_equal("m_tvalid", 64'(e == TPJ + RESULT_LAT), 64'(m_tvalid));
        end
        // done held while m_tready is low, start attempts refused
        stall = $urandom_range(1, MAX_STALL);
        repeat (stall) begin
            @(posedge clk);
            s_tvalid <= 1'b1;
            drive_ignored_load();
            @(negedge clk);
            check_equal("m_tvalid held", 64'(1), 64'(m_tvalid));
            check_equal("s_tready in done", 64'(0), 64'(s_tready));
        end
        @(posedge clk);
        m_tready <= 1'b1;
        s_tvalid <= 1'b0;
        load_en  <= 1'b0;
        @(negedge clk);
        check_equal("m_tvalid before ack edge", 64'(1), 64'(m_tvalid));
        @(posedge clk);
        @(negedge clk);
        check_equal("m_tvalid after ack", 64'(0), 64'(m_tvalid));
        check_equal("s_tready back in idle", 64'(1), 64'(s_tready));
    endtask

    // ======================================================================
    // watchdog
    // ======================================================================
    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("watchdog expired, the run did not finish in %0d cycles", WATCHDOG_CYC);
        $display("Testbench failed");
        $finish;
    end

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        void'($urandom(32'h8cb2_e799));
        test_errors  = 0;
        total_errors = 0;
        failed_tests = 0;
        tests_run    = 0;
        rst_n       = 1'b0;
        s_tvalid    = 1'b0;
        m_tready    = 1'b0;
        load_en     = 1'b0;
        load_target = LOAD_WEIGHT;
        load_addr   = '0;
        load_data   = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        cur_test = "reset";
        @(negedge clk);
        check_equal("m_tvalid", 64'(0), 64'(m_tvalid));
        check_equal("result_valid", 64'(0), 64'(result_valid));
        check_equal("s_tready with m_tready low", 64'(0), 64'(s_tready));
        @(posedge clk);
        m_tready <= 1'b1;
        @(negedge clk);
        check_equal("s_tready with m_tready high", 64'(1), 64'(s_tready));
        close_test();

        for (int t = 0; t < TPJ; t++) write_load(LOAD_WEIGHT, t);
        for (int k = 0; k < XT_DEPTH; k++) write_load(LOAD_XT, k);
        for (int t = 0; t < TPJ; t++) write_load(LOAD_BIAS, t);
        @(posedge clk);
        load_en <= 1'b0;

        for (int j = 0; j < N_JOBS; j++) begin
            cur_test = $sformatf("job_%0d", j);
            run_job();
            close_test();
        end

        $display("summary: %0d tests, %0d failed, %0d errors",
                 tests_run, failed_tests, total_errors);
        if (total_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- verilog/slim_mac_top.sv
// =========================================================================
// top level of the tile MAC engine
// load weights, xt and biases while idle, start a job with s_tvalid,
// collect one result vector per cycle, then acknowledge done on m_tready
// =========================================================================
module slim_mac_top #(
    parameter int  TILE_SIZE     = slim_mac_pkg::TILE_SIZE_D,
    parameter int  DATA_WIDTH    = slim_mac_pkg::DATA_WIDTH_D,
    parameter int  ACC_WIDTH     = slim_mac_pkg::ACC_WIDTH_D,
    parameter int  FRAC_BITS     = slim_mac_pkg::FRAC_BITS_D,
    parameter int  N_BANK        = slim_mac_pkg::N_BANK_D,
    parameter int  TILES_PER_JOB = slim_mac_pkg::TILES_PER_JOB_D,
    parameter int  X_GROUP       = slim_mac_pkg::X_GROUP_D,
    localparam int IDX_W         = (TILES_PER_JOB > 1) ? $clog2(TILES_PER_JOB) : 1
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   s_tvalid,
    output logic                                   s_tready,
    output logic                                   m_tvalid,
    input  logic                                   m_tready,
    input  logic                                   load_en,
    input  slim_mac_pkg::load_target_e             load_target,
    input  logic [IDX_W-1:0]                       load_addr,
    input  logic [TILE_SIZE*TILE_SIZE*DATA_WIDTH-1:0] load_data,
    output logic                                   result_valid,
    output logic [IDX_W-1:0]                       result_tile,
    output logic [TILE_SIZE*DATA_WIDTH-1:0]        result_vec
);
    localparam int WORD_W   = TILE_SIZE * TILE_SIZE * DATA_WIDTH;
    localparam int XT_DEPTH = (TILES_PER_JOB + X_GROUP - 1) / X_GROUP;

    logic                           weight_wr;
    logic                           xt_wr;
    logic                           bias_wr;
    logic [WORD_W-1:0]              w_tile;
    logic                           sum_valid;
    logic [IDX_W-1:0]               sum_tile;
    logic [TILE_SIZE*ACC_WIDTH-1:0] sum_vec;
    logic                           last_out;

    tile_issue_if #(
        .N_BANK        (N_BANK),
        .TILES_PER_JOB (TILES_PER_JOB),
        .X_GROUP       (X_GROUP)
    ) issue_bus ();

    // decode
    tile_decode #(
        .N_BANK        (N_BANK),
        .TILES_PER_JOB (TILES_PER_JOB),
        .X_GROUP       (X_GROUP)
    ) u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .s_tvalid    (s_tvalid),
        .s_tready    (s_tready),
        .m_tvalid    (m_tvalid),
        .m_tready    (m_tready),
        .load_en     (load_en),
        .load_target (load_target),
        .weight_wr   (weight_wr),
        .xt_wr       (xt_wr),
        .bias_wr     (bias_wr),
        .issue       (issue_bus.decode),
        .last_result (last_out)
    );

    // weight banks, one cycle behind the issue strobe
    weight_bank_store #(
        .N_BANK        (N_BANK),
        .TILES_PER_JOB (TILES_PER_JOB),
        .WORD_W        (WORD_W)
    ) u_store (
        .clk       (clk),
        .rst_n     (rst_n),
        .weight_wr (weight_wr),
        .load_addr (load_addr),
        .load_data (load_data),
        .issue     (issue_bus.store),
        .w_tile    (w_tile)
    );

    // execute
    mac_execute #(
        .TILE_SIZE  (TILE_SIZE),
        .DATA_WIDTH (DATA_WIDTH),
        .ACC_WIDTH  (ACC_WIDTH),
        .XT_DEPTH   (XT_DEPTH),
        .IDX_W      (IDX_W)
    ) u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .xt_wr     (xt_wr),
        .load_addr (load_addr),
        .load_data (load_data),
        .issue     (issue_bus.execute),
        .w_tile    (w_tile),
        .sum_valid (sum_valid),
        .sum_tile  (sum_tile),
        .sum_vec   (sum_vec)
    );

    // result
    bias_result #(
        .TILE_SIZE     (TILE_SIZE),
        .DATA_WIDTH    (DATA_WIDTH),
        .ACC_WIDTH     (ACC_WIDTH),
        .FRAC_BITS     (FRAC_BITS),
        .TILES_PER_JOB (TILES_PER_JOB)
    ) u_result (
        .clk          (clk),
        .rst_n        (rst_n),
        .bias_wr      (bias_wr),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .sum_valid    (sum_valid),
        .sum_tile     (sum_tile),
        .sum_vec      (sum_vec),
        .result_valid (result_valid),
        .result_tile  (result_tile),
        .result_vec   (result_vec),
        .last_out     (last_out)
    );

endmodule

//--- verilog/bias_result.sv
// =========================================================================
// output stage, drops FRAC_BITS from each lane sum, truncates to
// DATA_WIDTH and adds the bias vector of the tile
// flags the final tile of the job on last_out
// =========================================================================
module bias_result #(
    parameter int  TILE_SIZE     = 4,
    parameter int  DATA_WIDTH    = 16,
    parameter int  ACC_WIDTH     = 32,
    parameter int  FRAC_BITS     = 8,
    parameter int  TILES_PER_JOB = 20,
    localparam int IDX_W         = (TILES_PER_JOB > 1) ? $clog2(TILES_PER_JOB) : 1
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   bias_wr,
    input  logic [IDX_W-1:0]                       load_addr,
    input  logic [TILE_SIZE*TILE_SIZE*DATA_WIDTH-1:0] load_data,
    input  logic                                   sum_valid,
    input  logic [IDX_W-1:0]                       sum_tile,
    input  logic [TILE_SIZE*ACC_WIDTH-1:0]         sum_vec,
    output logic                                   result_valid,
    output logic [IDX_W-1:0]                       result_tile,
    output logic [TILE_SIZE*DATA_WIDTH-1:0]        result_vec,
    output logic                                   last_out
);
    localparam int VEC_W = TILE_SIZE * DATA_WIDTH;

    logic [VEC_W-1:0]            bias_mem [TILES_PER_JOB];
    logic [VEC_W-1:0]            bias_vec;
    logic signed [ACC_WIDTH-1:0] shifted [TILE_SIZE];

    always_ff @(posedge clk) begin
        if (bias_wr && int'(load_addr) < TILES_PER_JOB) begin
            bias_mem[load_addr] <= load_data[VEC_W-1:0];
        end
    end

    assign bias_vec = bias_mem[sum_tile];

    // arithmetic shift keeps the sign of the lane sum
    always_comb begin
        for (int i = 0; i < TILE_SIZE; i++) begin
            shifted[i] = $signed(sum_vec[i*ACC_WIDTH +: ACC_WIDTH]) >>> FRAC_BITS;
        end
    end

    // add wraps modulo 2^DATA_WIDTH
    always_ff @(posedge clk) begin
        if (sum_valid) begin
            for (int i = 0; i < TILE_SIZE; i++) begin
                result_vec[i*DATA_WIDTH +: DATA_WIDTH] <= shifted[i][DATA_WIDTH-1:0]
                                                        + bias_vec[i*DATA_WIDTH +: DATA_WIDTH];
            end
            result_tile <= sum_tile;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            last_out     <= 1'b0;
        end else begin
            result_valid <= sum_valid;
            last_out     <= sum_valid && (sum_tile == IDX_W'(TILES_PER_JOB - 1));
        end
    end

    // results of one job leave back to back and in tile order
    a_tile_order: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && !last_out |=> result_valid && result_tile == $past(result_tile) + 1'b1);

endmodule

//--- verilog/mac_execute.sv
// =========================================================================
// tile times vector datapath
// holds the xt vectors, multiplies each weight element by its xt element
// and reduces each row to one signed ACC_WIDTH sum, two cycles after w_tile
// =========================================================================
module mac_execute #(
    parameter int TILE_SIZE  = 4,
    parameter int DATA_WIDTH = 16,
    parameter int ACC_WIDTH  = 32,
    parameter int XT_DEPTH   = 4,
    parameter int IDX_W      = 5
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   xt_wr,
    input  logic [IDX_W-1:0]                       load_addr,
    input  logic [TILE_SIZE*TILE_SIZE*DATA_WIDTH-1:0] load_data,
    tile_issue_if.execute                          issue,
    input  logic [TILE_SIZE*TILE_SIZE*DATA_WIDTH-1:0] w_tile,
    output logic                                   sum_valid,
    output logic [IDX_W-1:0]                       sum_tile,
    output logic [TILE_SIZE*ACC_WIDTH-1:0]         sum_vec
);
    localparam int VEC_W = TILE_SIZE * DATA_WIDTH;
    localparam int XT_W  = (XT_DEPTH > 1) ? $clog2(XT_DEPTH) : 1;

    logic [VEC_W-1:0]            xt_mem [XT_DEPTH];
    logic [VEC_W-1:0]            xt_q;
    logic                        rd_valid;
    logic [IDX_W-1:0]            rd_tile;
    logic                        prod_valid;
    logic [IDX_W-1:0]            prod_tile;
    logic signed [ACC_WIDTH-1:0] prod [TILE_SIZE][TILE_SIZE];
    logic signed [ACC_WIDTH-1:0] lane_sum [TILE_SIZE];

    // xt vectors sit in the low VEC_W bits of the load word
    always_ff @(posedge clk) begin
        if (xt_wr && int'(load_addr) < XT_DEPTH) begin
            xt_mem[load_addr[XT_W-1:0]] <= load_data[VEC_W-1:0];
        end
    end

    // ======================================================================
    // stage 1 lines up with the bank read
    // ======================================================================
    always_ff @(posedge clk) begin
        if (issue.valid) begin
            xt_q    <= xt_mem[issue.xt_idx];
            rd_tile <= issue.tile_idx;
        end
    end

    // stage 2, one signed product per element
    always_ff @(posedge clk) begin
        if (rd_valid) begin
            for (int i = 0; i < TILE_SIZE; i++) begin
                for (int j = 0; j < TILE_SIZE; j++) begin
                    prod[i][j] <= $signed(w_tile[(i*TILE_SIZE+j)*DATA_WIDTH +: DATA_WIDTH])
                                * $signed(xt_q[j*DATA_WIDTH +: DATA_WIDTH]);
                end
            end
            prod_tile <= rd_tile;
        end
    end

    // row reduction
    always_comb begin
        for (int i = 0; i < TILE_SIZE; i++) begin
            lane_sum[i] = '0;
            for (int j = 0; j < TILE_SIZE; j++) begin
                lane_sum[i] = lane_sum[i] + prod[i][j];
            end
        end
    end

    // stage 3, registered sums
    always_ff @(posedge clk) begin
        if (prod_valid) begin
            for (int i = 0; i < TILE_SIZE; i++) begin
                sum_vec[i*ACC_WIDTH +: ACC_WIDTH] <= lane_sum[i];
            end
            sum_tile <= prod_tile;
        end
    end

    // valid travels beside the data, several tiles in flight
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid   <= 1'b0;
            prod_valid <= 1'b0;
            sum_valid  <= 1'b0;
        end else begin
            rd_valid   <= issue.valid;
            prod_valid <= rd_valid;
            sum_valid  <= prod_valid;
        end
    end

endmodule

//--- verilog/tile_decode.sv
// =========================================================================
// job control for the MAC engine
// runs the IDLE/RUN/DONE FSM, issues one tile per cycle with its bank,
// bank row and xt index, and gates the load port to IDLE
// =========================================================================
module tile_decode #(
    parameter int N_BANK        = 6,
    parameter int TILES_PER_JOB = 20,
    parameter int X_GROUP       = 5
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       s_tvalid,
    output logic                       s_tready,
    output logic                       m_tvalid,
    input  logic                       m_tready,
    input  logic                       load_en,
    input  slim_mac_pkg::load_target_e load_target,
    output logic                       weight_wr,
    output logic                       xt_wr,
    output logic                       bias_wr,
    tile_issue_if.decode               issue,
    input  logic                       last_result
);
    import slim_mac_pkg::*;

    localparam int IDX_W    = (TILES_PER_JOB > 1) ? $clog2(TILES_PER_JOB) : 1;
    localparam int BANK_W   = (N_BANK > 1) ? $clog2(N_BANK) : 1;
    localparam int DEPTH    = (TILES_PER_JOB + N_BANK - 1) / N_BANK;
    localparam int ADDR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int XT_DEPTH = (TILES_PER_JOB + X_GROUP - 1) / X_GROUP;
    localparam int XT_W     = (XT_DEPTH > 1) ? $clog2(XT_DEPTH) : 1;
    localparam int GRP_W    = (X_GROUP > 1) ? $clog2(X_GROUP) : 1;

    state_e            state;
    logic              start_fire;
    logic              load_ok;
    // high while tiles of the current job remain to be issued
    logic              busy;
    logic [IDX_W-1:0]  tile_cnt;
    logic [BANK_W-1:0] bank_cnt;
    logic [ADDR_W-1:0] addr_cnt [N_BANK];
    logic [GRP_W-1:0]  grp_cnt;
    logic [XT_W-1:0]   xt_cnt;

    // ======================================================================
    // handshake and load gating
    // ======================================================================
    // a new job is only taken when the consumer of done is ready too
    assign s_tready   = (state == IDLE) && m_tready;
    assign start_fire = s_tvalid && s_tready;
    assign m_tvalid   = (state == DONE);

    assign load_ok   = load_en && (state == IDLE);
    assign weight_wr = load_ok && (load_target == LOAD_WEIGHT);
    assign xt_wr     = load_ok && (load_target == LOAD_XT);
    assign bias_wr   = load_ok && (load_target == LOAD_BIAS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (start_fire) state <= RUN;
                // last result seen at the output of bias_result
                RUN:     if (last_result) state <= DONE;
                DONE:    if (m_tready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // ======================================================================
    // tile issue
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            issue.valid <= 1'b0;
            tile_cnt    <= '0;
            bank_cnt    <= '0;
            grp_cnt     <= '0;
            xt_cnt      <= '0;
            for (int b = 0; b < N_BANK; b++) begin
                addr_cnt[b] <= '0;
            end
        end else if (start_fire) begin
            // fresh job clears all bank rows
            busy        <= 1'b1;
            issue.valid <= 1'b0;
            tile_cnt    <= '0;
            bank_cnt    <= '0;
            grp_cnt     <= '0;
            xt_cnt      <= '0;
            for (int b = 0; b < N_BANK; b++) begin
                addr_cnt[b] <= '0;
            end
        end else if (busy) begin
            issue.valid <= 1'b1;
            // only the bank being read moves on
            addr_cnt[bank_cnt] <= addr_cnt[bank_cnt] + 1'b1;
            bank_cnt <= (bank_cnt == BANK_W'(N_BANK - 1)) ? '0 : bank_cnt + 1'b1;
            // xt index steps every X_GROUP tiles
            if (grp_cnt == GRP_W'(X_GROUP - 1)) begin
                grp_cnt <= '0;
                xt_cnt  <= xt_cnt + 1'b1;
            end else begin
                grp_cnt <= grp_cnt + 1'b1;
            end
            tile_cnt <= tile_cnt + 1'b1;
            if (tile_cnt == IDX_W'(TILES_PER_JOB - 1)) begin
                busy <= 1'b0;
            end
        end else begin
            issue.valid <= 1'b0;
        end
    end

    // issue payload qualified by issue.valid
    always_ff @(posedge clk) begin
        if (busy) begin
            issue.tile_idx  <= tile_cnt;
            issue.bank      <= bank_cnt;
            issue.bank_addr <= addr_cnt[bank_cnt];
            issue.xt_idx    <= xt_cnt;
        end
    end

    // each bank holds only the rows of the tiles that map onto it
    a_addr_in_bank: assert property (@(posedge clk) disable iff (!rst_n)
        issue.valid |-> int'(issue.bank_addr) * N_BANK + int'(issue.bank) < TILES_PER_JOB);

    a_issue_in_run: assert property (@(posedge clk) disable iff (!rst_n)
        issue.valid |-> state == RUN);

endmodule

//--- verilog/weight_bank_store.sv
// =========================================================================
// weight tile storage split over N_BANK banks
// tile t lives in bank t mod N_BANK at row t div N_BANK
// loads come from the load port, reads are registered on an issue strobe
// =========================================================================
module weight_bank_store #(
    parameter int  N_BANK        = 6,
    parameter int  TILES_PER_JOB = 20,
    parameter int  WORD_W        = 256,
    localparam int IDX_W         = (TILES_PER_JOB > 1) ? $clog2(TILES_PER_JOB) : 1
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              weight_wr,
    input  logic [IDX_W-1:0]  load_addr,
    input  logic [WORD_W-1:0] load_data,
    tile_issue_if.store       issue,
    output logic [WORD_W-1:0] w_tile
);
    localparam int BANK_W = (N_BANK > 1) ? $clog2(N_BANK) : 1;
    localparam int DEPTH  = (TILES_PER_JOB + N_BANK - 1) / N_BANK;
    localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WORD_W-1:0] bank_mem [N_BANK][DEPTH];
    logic [BANK_W-1:0] wr_bank;
    logic [ADDR_W-1:0] wr_addr;

    // round-robin mapping of the flat tile address
    assign wr_bank = BANK_W'(load_addr % N_BANK);
    assign wr_addr = ADDR_W'(load_addr / N_BANK);

    always_ff @(posedge clk) begin
        if (weight_wr && int'(load_addr) < TILES_PER_JOB) begin
            bank_mem[wr_bank][wr_addr] <= load_data;
        end
    end

    // read port, one cycle from issue to w_tile
    always_ff @(posedge clk) begin
        if (issue.valid) begin
            w_tile <= bank_mem[issue.bank][issue.bank_addr];
        end
    end

    // loads are gated to IDLE by the decoder, so they never meet a read
    a_no_wr_during_rd: assert property (@(posedge clk) disable iff (!rst_n)
        !(weight_wr && issue.valid));

endmodule

//--- verilog/tile_issue_if.sv
// =========================================================================
// per-tile issue bundle, driven by the decoder once per issued tile
// execute and the weight banks only listen, there is no back-pressure
// =========================================================================
interface tile_issue_if #(
    parameter int N_BANK        = 6,
    parameter int TILES_PER_JOB = 20,
    parameter int X_GROUP       = 5
);
    localparam int IDX_W    = (TILES_PER_JOB > 1) ? $clog2(TILES_PER_JOB) : 1;
    localparam int BANK_W   = (N_BANK > 1) ? $clog2(N_BANK) : 1;
    localparam int DEPTH    = (TILES_PER_JOB + N_BANK - 1) / N_BANK;
    localparam int ADDR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int XT_DEPTH = (TILES_PER_JOB + X_GROUP - 1) / X_GROUP;
    localparam int XT_W     = (XT_DEPTH > 1) ? $clog2(XT_DEPTH) : 1;

    // one-cycle strobe per tile
    logic              valid;
    logic [IDX_W-1:0]  tile_idx;
    logic [BANK_W-1:0] bank;
    logic [ADDR_W-1:0] bank_addr;
    logic [XT_W-1:0]   xt_idx;

    modport decode  (output valid, tile_idx, bank, bank_addr, xt_idx);
    modport execute (input valid, tile_idx, xt_idx);
    modport store   (input valid, bank, bank_addr);

endinterface

//--- verilog/slim_mac_pkg.sv
// =========================================================================
// shared types and default sizes for the tile MAC engine
// the top level takes its parameter defaults from the *_D constants
// =========================================================================
package slim_mac_pkg;

    // job FSM states
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        DONE = 2'd2
    } state_e;

    // destination of a word on the load port
    typedef enum logic [1:0] {
        LOAD_WEIGHT = 2'd0,
        LOAD_XT     = 2'd1,
        LOAD_BIAS   = 2'd2
    } load_target_e;

    // tile geometry and fixed-point format
    localparam int TILE_SIZE_D  = 4;
    localparam int DATA_WIDTH_D = 16;
    localparam int ACC_WIDTH_D  = 32;
    localparam int FRAC_BITS_D  = 8;

    // job shape
    localparam int N_BANK_D        = 6;
    localparam int TILES_PER_JOB_D = 20;
    localparam int X_GROUP_D       = 5;

endpackage
